//--- armExec.f
+incdir+.
armExecPkg.sv
resultIf.sv
aluPath.sv
mulUnit.sv
writeMerge.sv
armExec.sv
tbArmExec.sv

//--- run.sh
#!/bin/bash
# Build and run the execute-stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f armExec.f --top-module tbArmExec &&
    ./obj_dir/VtbArmExec > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q -F '*** PASSED ***' sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }

//--- tbArmExecTable.svh
// One row per operation with cond, opcode, setFlags, imm, mul, src2, rd, rn, rm,
// then write expected, write address, write data and flags after acceptance (NZCV)
localparam int NumRows = 22;

opRow_t opTable [NumRows] = '{
    // Rotated immediate and the four shift types
    '{armExecPkg::CondAl, armExecPkg::OpMov, 1'b1, 1'b1, 1'b0, 12'h4FF, 4'd1,
      32'h00000000, 32'h00000000, 1'b1, 4'd1, 32'hFF000000, 4'b1000},
    '{armExecPkg::CondAl, armExecPkg::OpAdd, 1'b1, 1'b1, 1'b0, 12'h001, 4'd2,
      32'h7FFFFFFF, 32'h00000000, 1'b1, 4'd2, 32'h80000000, 4'b1001},
    '{armExecPkg::CondAl, armExecPkg::OpSub, 1'b1, 1'b0, 1'b0, 12'h100, 4'd3,
      32'h00000005, 32'h00000003, 1'b1, 4'd3, 32'hFFFFFFF9, 4'b1000},
    '{armExecPkg::CondAl, armExecPkg::OpMov, 1'b1, 1'b0, 1'b0, 12'h220, 4'd4,
      32'h00000000, 32'h000000F8, 1'b1, 4'd4, 32'h0000000F, 4'b0010},
    '{armExecPkg::CondAl, armExecPkg::OpMov, 1'b0, 1'b0, 1'b0, 12'h440, 4'd5,
      32'h00000000, 32'h80001234, 1'b1, 4'd5, 32'hFF800012, 4'b0010},
    '{armExecPkg::CondAl, armExecPkg::OpEor, 1'b1, 1'b0, 1'b0, 12'h860, 4'd6,
      32'h0000FFFF, 32'h12345678, 1'b1, 4'd6, 32'h5678EDCB, 4'b0000},
    // Compare, carry-in and conditions
    '{armExecPkg::CondAl, armExecPkg::OpCmp, 1'b1, 1'b1, 1'b0, 12'h00A, 4'd0,
      32'h0000000A, 32'h00000000, 1'b0, 4'd0, 32'h00000000, 4'b0110},
    '{armExecPkg::CondAl, armExecPkg::OpAdc, 1'b0, 1'b1, 1'b0, 12'h020, 4'd7,
      32'h00000010, 32'h00000000, 1'b1, 4'd7, 32'h00000031, 4'b0110},
    '{armExecPkg::CondNe, armExecPkg::OpAdd, 1'b1, 1'b1, 1'b0, 12'h001, 4'd8,
      32'h00000001, 32'h00000000, 1'b0, 4'd8, 32'h00000000, 4'b0110},
    '{armExecPkg::CondEq, armExecPkg::OpAdd, 1'b1, 1'b1, 1'b0, 12'h002, 4'd8,
      32'h00000001, 32'h00000000, 1'b1, 4'd8, 32'h00000003, 4'b0000},
    '{armExecPkg::CondAl, armExecPkg::OpCmn, 1'b1, 1'b1, 1'b0, 12'h001, 4'd0,
      32'hFFFFFFFF, 32'h00000000, 1'b0, 4'd0, 32'h00000000, 4'b0110},
    '{armExecPkg::CondAl, armExecPkg::OpTst, 1'b1, 1'b0, 1'b0, 12'h080, 4'd0,
      32'h80000000, 32'hC0000000, 1'b0, 4'd0, 32'h00000000, 4'b1010},
    // Multiply with independent ALU work behind it
    '{armExecPkg::CondAl, armExecPkg::OpAnd, 1'b0, 1'b0, 1'b1, 12'h000, 4'd9,
      32'h00012345, 32'h00010001, 1'b1, 4'd9, 32'h23462345, 4'b1010},
    '{armExecPkg::CondAl, armExecPkg::OpOrr, 1'b0, 1'b1, 1'b0, 12'h0F0, 4'd10,
      32'h0F0F0000, 32'h00000000, 1'b1, 4'd10, 32'h0F0F00F0, 4'b1010},
    '{armExecPkg::CondAl, armExecPkg::OpBic, 1'b1, 1'b1, 1'b0, 12'h0FF, 4'd11,
      32'hFFFFFFFF, 32'h00000000, 1'b1, 4'd11, 32'hFFFFFF00, 4'b1010},
    '{armExecPkg::CondAl, armExecPkg::OpMvn, 1'b0, 1'b1, 1'b0, 12'h000, 4'd12,
      32'h00000000, 32'h00000000, 1'b1, 4'd12, 32'hFFFFFFFF, 4'b1010},
    // Same destination as a busy multiply
    '{armExecPkg::CondAl, armExecPkg::OpAnd, 1'b0, 1'b0, 1'b1, 12'h000, 4'd13,
      32'hFFFFFFFF, 32'hFFFFFFFF, 1'b1, 4'd13, 32'h00000001, 4'b1010},
    '{armExecPkg::CondAl, armExecPkg::OpRsb, 1'b1, 1'b1, 1'b0, 12'h064, 4'd13,
      32'h00000001, 32'h00000000, 1'b1, 4'd13, 32'h00000063, 4'b0010},
    '{armExecPkg::CondAl, armExecPkg::OpAnd, 1'b1, 1'b1, 1'b0, 12'h8FF, 4'd14,
      32'hFFFF0000, 32'h00000000, 1'b1, 4'd14, 32'h00FF0000, 4'b0010},
    '{armExecPkg::CondAl, armExecPkg::OpAnd, 1'b0, 1'b0, 1'b1, 12'h000, 4'd15,
      32'h00000007, 32'h00000006, 1'b1, 4'd15, 32'h0000002A, 4'b0010},
    '{armExecPkg::CondLt, armExecPkg::OpMov, 1'b1, 1'b1, 1'b0, 12'h0AA, 4'd0,
      32'h00000000, 32'h00000000, 1'b0, 4'd0, 32'h00000000, 4'b0010},
    '{armExecPkg::CondGe, armExecPkg::OpMov, 1'b1, 1'b1, 1'b0, 12'h055, 4'd0,
      32'h00000000, 32'h00000000, 1'b1, 4'd0, 32'h00000055, 4'b0010}
};

//--- tbArmExec.sv
`timescale 1ns/10ps

module tbArmExec;

    typedef struct packed {
        logic [3:0]                          cond;
        logic [3:0]                          code;
        logic                                setFlags;
        logic                                imm;
        logic                                mul;
        logic [11:0]                         src2;
        logic [armExecPkg::RegAddrWidth-1:0] rd;
        logic [armExecPkg::DataWidth-1:0]    rn;
        logic [armExecPkg::DataWidth-1:0]    rm;
        logic                                expWrite;
        logic [armExecPkg::RegAddrWidth-1:0] expAddr;
        logic [armExecPkg::DataWidth-1:0]    expData;
        logic [3:0]                          expFlags;
    } opRow_t;

    typedef struct packed {
        logic [armExecPkg::RegAddrWidth-1:0] addr;
        logic [armExecPkg::DataWidth-1:0]    data;
    } expWrite_t;

    `include "tbArmExecTable.svh"

    localparam int CycleLimit = 40 * NumRows + 100;
    localparam int DrainLimit = 40;

    logic                                CLK;
    logic                                rstN;
    logic                                opReq;
    logic                                opAck;
    logic [3:0]                          opCond;
    logic [3:0]                          opCode;
    logic                                opSetFlags;
    logic                                opImm;
    logic                                opMul;
    logic [11:0]                         opSrc2;
    logic [armExecPkg::RegAddrWidth-1:0] opRd;
    logic [armExecPkg::DataWidth-1:0]    rnData;
    logic [armExecPkg::DataWidth-1:0]    rmData;
    logic                                wbValid;
    logic [armExecPkg::RegAddrWidth-1:0] wbAddr;
    logic [armExecPkg::DataWidth-1:0]    wbData;
    logic [3:0]                          flags;

    expWrite_t aluQueue [$];
    expWrite_t mulQueue [$];
    expWrite_t wrHead;
    int        cycleCount = 0;

    armExec #(
        .mulBitsPerCycle (2)
    ) armExec_i (
        .CLK        (CLK),
        .rstN       (rstN),
        .opReq      (opReq),
        .opAck      (opAck),
        .opCond     (opCond),
        .opCode     (opCode),
        .opSetFlags (opSetFlags),
        .opImm      (opImm),
        .opMul      (opMul),
        .opSrc2     (opSrc2),
        .opRd       (opRd),
        .rnData     (rnData),
        .rmData     (rmData),
        .wbValid    (wbValid),
        .wbAddr     (wbAddr),
        .wbData     (wbData),
        .flags      (flags)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    ////////////////////////////////////////
    // Failure handling and compares
    ////////////////////////////////////////
    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkData(input string name, input logic [armExecPkg::DataWidth-1:0] got,
                             input logic [armExecPkg::DataWidth-1:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic checkAddr(input string name,
                             input logic [armExecPkg::RegAddrWidth-1:0] got,
                             input logic [armExecPkg::RegAddrWidth-1:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
                               $time, name, got, exp));
        end
    endtask

    task automatic checkFlags(input string name, input logic [3:0] got,
                              input logic [3:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                               $time, name, got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                               $time, name, got, exp));
        end
    endtask

    task automatic driveRow(input opRow_t row);
        opReq      <= 1'b1;
        opCond     <= row.cond;
        opCode     <= row.code;
        opSetFlags <= row.setFlags;
        opImm      <= row.imm;
        opMul      <= row.mul;
        opSrc2     <= row.src2;
        opRd       <= row.rd;
        rnData     <= row.rn;
        rmData     <= row.rm;
    endtask

    ////////////////////////////////////////
    // Write checker and timeout
    ////////////////////////////////////////
    // Multiply has priority, so a matching multiply head is taken first
    always @(negedge CLK) begin
        if (rstN && wbValid) begin
            if (mulQueue.size() != 0 && mulQueue[0].addr == wbAddr) begin
                wrHead = mulQueue.pop_front();
                checkData("wbData", wbData, wrHead.data);
            end else if (aluQueue.size() != 0) begin
                wrHead = aluQueue.pop_front();
                checkAddr("wbAddr", wbAddr, wrHead.addr);
                checkData("wbData", wbData, wrHead.data);
            end else begin
                abortRun($sformatf("Unexpected register write to r%0d at %0t", wbAddr, $time));
            end
        end
    end

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            abortRun($sformatf("Timeout after %0d cycles, the run did not finish", cycleCount));
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        int        gap;
        expWrite_t pending;

        rstN       = 1'b0;
        opReq      = 1'b0;
        opCond     = '0;
        opCode     = '0;
        opSetFlags = 1'b0;
        opImm      = 1'b0;
        opMul      = 1'b0;
        opSrc2     = '0;
        opRd       = '0;
        rnData     = '0;
        rmData     = '0;
        void'($urandom(32'hc20f));

        repeat (2) @(posedge CLK);
        rstN <= 1'b1;
        @(negedge CLK);
        checkBit("wbValid", wbValid, 1'b0);
        checkBit("opAck", opAck, 1'b0);
        checkFlags("flags", flags, 4'b0000);

        for (int i = 0; i < NumRows; i++) begin
            gap = $urandom % 4;
            repeat (gap) @(posedge CLK);
            @(posedge CLK);
            driveRow(opTable[i]);
            if (opTable[i].expWrite) begin
                pending.addr = opTable[i].expAddr;
                pending.data = opTable[i].expData;
                if (opTable[i].mul) begin
                    mulQueue.push_back(pending);
                end else begin
                    aluQueue.push_back(pending);
                end
            end
            do begin
                @(negedge CLK);
            end while (!opAck);
            checkFlags("flags", flags, opTable[i].expFlags);
            @(posedge CLK);
            opReq <= 1'b0;
            do begin
                @(negedge CLK);
            end while (opAck);
        end

        // Let outstanding writes drain
        for (int w = 0; w < DrainLimit; w++) begin
            if (aluQueue.size() == 0 && mulQueue.size() == 0) begin
                break;
            end
            @(negedge CLK);
        end
        repeat (5) @(negedge CLK);

        if (aluQueue.size() != 0 || mulQueue.size() != 0) begin
            abortRun($sformatf("%0d ALU and %0d multiply writes never appeared",
                               aluQueue.size(), mulQueue.size()));
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

//--- armExec.sv
`timescale 1ns/10ps

module armExec #(
    parameter int mulBitsPerCycle = 2
) (
    input  logic                                 CLK,
    input  logic                                 rstN,

    input  logic                                 opReq,
    output logic                                 opAck,
    input  logic [3:0]                           opCond,
    input  logic [3:0]                           opCode,
    input  logic                                 opSetFlags,
    input  logic                                 opImm,
    input  logic                                 opMul,
    input  logic [11:0]                          opSrc2,
    input  logic [armExecPkg::RegAddrWidth-1:0]  opRd,
    input  logic [armExecPkg::DataWidth-1:0]     rnData,
    input  logic [armExecPkg::DataWidth-1:0]     rmData,

    output logic                                 wbValid,
    output logic [armExecPkg::RegAddrWidth-1:0]  wbAddr,
    output logic [armExecPkg::DataWidth-1:0]     wbData,
    output logic [3:0]                           flags
);

    logic aluAck, mulAck, mulBusy;
    logic [armExecPkg::RegAddrWidth-1:0] mulRd;

    resultIf aluRes ();
    resultIf mulRes ();

    // Only the path selected by opMul ever acknowledges
    assign opAck = aluAck | mulAck;

    aluPath aluPath_i (
        .CLK        (CLK),
        .rstN       (rstN),
        .opReq      (opReq),
        .opAck      (aluAck),
        .opMul      (opMul),
        .opCond     (opCond),
        .opCode     (opCode),
        .opSetFlags (opSetFlags),
        .opImm      (opImm),
        .opSrc2     (opSrc2),
        .opRd       (opRd),
        .rnData     (rnData),
        .rmData     (rmData),
        .mulBusy    (mulBusy),
        .mulRd      (mulRd),
        .flags      (flags),
        .res        (aluRes)
    );

    mulUnit #(
        .mulBitsPerCycle (mulBitsPerCycle)
    ) mulUnit_i (
        .CLK     (CLK),
        .rstN    (rstN),
        .opReq   (opReq),
        .opAck   (mulAck),
        .opMul   (opMul),
        .opRd    (opRd),
        .rnData  (rnData),
        .rmData  (rmData),
        .mulBusy (mulBusy),
        .mulRd   (mulRd),
        .res     (mulRes)
    );

    writeMerge writeMerge_i (
        .CLK     (CLK),
        .rstN    (rstN),
        .mulIn   (mulRes),
        .aluIn   (aluRes),
        .wbValid (wbValid),
        .wbAddr  (wbAddr),
        .wbData  (wbData)
    );

endmodule

//--- writeMerge.sv
`timescale 1ns/10ps

module writeMerge (
    input  logic                                 CLK,
    input  logic                                 rstN,
    resultIf.sink                                mulIn,
    resultIf.sink                                aluIn,
    output logic                                 wbValid,
    output logic [armExecPkg::RegAddrWidth-1:0]  wbAddr,
    output logic [armExecPkg::DataWidth-1:0]     wbData
);

    logic mulAckQ, aluAckQ, wbValidQ;
    logic idle, selMul, selAlu;
    logic [armExecPkg::RegAddrWidth-1:0] wbAddrQ;
    logic [armExecPkg::DataWidth-1:0]    wbDataQ;

    // One handshake in flight at a time with the multiplier first
    assign idle   = !mulAckQ && !aluAckQ;
    assign selMul = idle && mulIn.req;
    assign selAlu = idle && aluIn.req && !mulIn.req;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            mulAckQ  <= 1'b0;
            aluAckQ  <= 1'b0;
            wbValidQ <= 1'b0;
        end else begin
            wbValidQ <= selMul || selAlu;
            if (selMul) begin
                mulAckQ <= 1'b1;
            end else if (!mulIn.req) begin
                mulAckQ <= 1'b0;
            end
            if (selAlu) begin
                aluAckQ <= 1'b1;
            end else if (!aluIn.req) begin
                aluAckQ <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (selMul) begin
            wbAddrQ <= mulIn.addr;
            wbDataQ <= mulIn.data;
        end else if (selAlu) begin
            wbAddrQ <= aluIn.addr;
            wbDataQ <= aluIn.data;
        end
    end

    assign mulIn.ack = mulAckQ;
    assign aluIn.ack = aluAckQ;
    assign wbValid   = wbValidQ;
    assign wbAddr    = wbAddrQ;
    assign wbData    = wbDataQ;

    assert property (@(posedge CLK) disable iff (!rstN)
        !(mulIn.ack && aluIn.ack));

endmodule

//--- mulUnit.sv
`timescale 1ns/10ps

module mulUnit #(
    parameter int mulBitsPerCycle = 2
) (
    input  logic                                 CLK,
    input  logic                                 rstN,
    input  logic                                 opReq,
    output logic                                 opAck,
    input  logic                                 opMul,
    input  logic [armExecPkg::RegAddrWidth-1:0]  opRd,
    input  logic [armExecPkg::DataWidth-1:0]     rnData,
    input  logic [armExecPkg::DataWidth-1:0]     rmData,
    output logic                                 mulBusy,
    output logic [armExecPkg::RegAddrWidth-1:0]  mulRd,
    resultIf.source                              res
);

    localparam int Dw       = armExecPkg::DataWidth;
    localparam int Steps    = Dw / mulBitsPerCycle;
    localparam int CntWidth = $clog2(Steps + 1);

    logic                 ackQ, busyQ, reqQ, accept;
    logic [CntWidth-1:0]  cntQ;
    logic [Dw-1:0]        mcandQ, mplierQ, accQ, partial;
    logic [armExecPkg::RegAddrWidth-1:0] rdQ;

    // New multiply only once the last write has fully completed
    assign accept = opReq && opMul && !busyQ && !ackQ && !res.ack;

    // Shift-add over the low multiplier bits
    always_comb begin
        partial = accQ;
        for (int i = 0; i < mulBitsPerCycle; i++) begin
            if (mplierQ[i]) begin
                partial = partial + (mcandQ << i);
            end
        end
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            ackQ  <= 1'b0;
            busyQ <= 1'b0;
            reqQ  <= 1'b0;
            cntQ  <= '0;
        end else begin
            if (accept) begin
                ackQ <= 1'b1;
            end else if (!opReq) begin
                ackQ <= 1'b0;
            end
            if (accept) begin
                busyQ <= 1'b1;
                cntQ  <= CntWidth'(Steps);
            end else if (cntQ != '0) begin
                cntQ <= cntQ - 1'b1;
                if (cntQ == CntWidth'(1)) begin
                    reqQ <= 1'b1;
                end
            end else if (reqQ && res.ack) begin
                reqQ  <= 1'b0;
                busyQ <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            mcandQ  <= rnData;
            mplierQ <= rmData;
            accQ    <= '0;
            rdQ     <= opRd;
        end else if (cntQ != '0) begin
            accQ    <= partial;
            mcandQ  <= mcandQ << mulBitsPerCycle;
            mplierQ <= mplierQ >> mulBitsPerCycle;
        end
    end

    assign opAck    = ackQ;
    assign mulBusy  = busyQ;
    assign mulRd    = rdQ;
    assign res.req  = reqQ;
    assign res.addr = rdQ;
    assign res.data = accQ;

    assert property (@(posedge CLK) disable iff (!rstN)
        mulBusy |=> !$rose(opAck));

endmodule

//--- aluPath.sv
`timescale 1ns/10ps

module aluPath (
    input  logic                                 CLK,
    input  logic                                 rstN,
    input  logic                                 opReq,
    output logic                                 opAck,
    input  logic                                 opMul,
    input  logic [3:0]                           opCond,
    input  logic [3:0]                           opCode,
    input  logic                                 opSetFlags,
    input  logic                                 opImm,
    input  logic [11:0]                          opSrc2,
    input  logic [armExecPkg::RegAddrWidth-1:0]  opRd,
    input  logic [armExecPkg::DataWidth-1:0]     rnData,
    input  logic [armExecPkg::DataWidth-1:0]     rmData,
    input  logic                                 mulBusy,
    input  logic [armExecPkg::RegAddrWidth-1:0]  mulRd,
    output logic [3:0]                           flags,
    resultIf.source                              res
);

    localparam int Dw = armExecPkg::DataWidth;

    armExecPkg::src2Field_t src2;
    logic [Dw-1:0] immWord, rotImm, op2, addA, addB, aluResult;
    logic [Dw:0]   sum;
    logic [4:0]    rotAmt;
    logic [3:0]    flagsQ, newFlags;
    logic          shCarry, addCin, isArith, noWrite, condPass, accept;
    logic          ackQ, reqQ;
    logic [armExecPkg::RegAddrWidth-1:0] addrQ;
    logic [Dw-1:0] dataQ;

    assign src2 = opSrc2;

    always_comb begin
        case (opCond)
            armExecPkg::CondEq: condPass = flagsQ[armExecPkg::FlagZ];
            armExecPkg::CondNe: condPass = !flagsQ[armExecPkg::FlagZ];
            armExecPkg::CondCs: condPass = flagsQ[armExecPkg::FlagC];
            armExecPkg::CondCc: condPass = !flagsQ[armExecPkg::FlagC];
            armExecPkg::CondMi: condPass = flagsQ[armExecPkg::FlagN];
            armExecPkg::CondPl: condPass = !flagsQ[armExecPkg::FlagN];
            armExecPkg::CondGe: condPass = flagsQ[armExecPkg::FlagN] == flagsQ[armExecPkg::FlagV];
            armExecPkg::CondLt: condPass = flagsQ[armExecPkg::FlagN] != flagsQ[armExecPkg::FlagV];
            armExecPkg::CondAl: condPass = 1'b1;
            default:            condPass = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // Operand 2 and shifter
    ////////////////////////////////////////
    assign immWord = {{(Dw - 8){1'b0}}, src2.immView.imm8};
    assign rotAmt  = {src2.immView.rot, 1'b0};
    assign rotImm  = (immWord >> rotAmt) | (immWord << (Dw - rotAmt));

    always_comb begin
        op2     = rmData;
        shCarry = flagsQ[armExecPkg::FlagC];
        if (opImm) begin
            op2 = rotImm;
        end else if (src2.regView.shAmt != 5'd0) begin
            // Last bit shifted out becomes the carry
            case (src2.regView.shType)
                armExecPkg::ShLsl: begin
                    op2     = rmData << src2.regView.shAmt;
                    shCarry = rmData[Dw - src2.regView.shAmt];
                end
                armExecPkg::ShLsr: begin
                    op2     = rmData >> src2.regView.shAmt;
                    shCarry = rmData[src2.regView.shAmt - 1];
                end
                armExecPkg::ShAsr: begin
                    op2     = $signed(rmData) >>> src2.regView.shAmt;
                    shCarry = rmData[src2.regView.shAmt - 1];
                end
                default: begin
                    op2     = (rmData >> src2.regView.shAmt) |
                              (rmData << (Dw - src2.regView.shAmt));
                    shCarry = rmData[src2.regView.shAmt - 1];
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////
    always_comb begin
        addA    = rnData;
        addB    = op2;
        addCin  = 1'b0;
        isArith = 1'b1;
        case (opCode)
            armExecPkg::OpSub, armExecPkg::OpCmp: begin
                addB   = ~op2;
                addCin = 1'b1;
            end
            armExecPkg::OpRsb: begin
                addA   = op2;
                addB   = ~rnData;
                addCin = 1'b1;
            end
            armExecPkg::OpAdc: addCin = flagsQ[armExecPkg::FlagC];
            armExecPkg::OpAdd, armExecPkg::OpCmn: addCin = 1'b0;
            default: isArith = 1'b0;
        endcase
    end

    assign sum = {1'b0, addA} + {1'b0, addB} + {{Dw{1'b0}}, addCin};

    always_comb begin
        case (opCode)
            armExecPkg::OpAnd, armExecPkg::OpTst: aluResult = rnData & op2;
            armExecPkg::OpEor: aluResult = rnData ^ op2;
            armExecPkg::OpOrr: aluResult = rnData | op2;
            armExecPkg::OpMov: aluResult = op2;
            armExecPkg::OpBic: aluResult = rnData & ~op2;
            armExecPkg::OpMvn: aluResult = ~op2;
            default:           aluResult = sum[Dw-1:0];
        endcase
    end

    always_comb begin
        newFlags = flagsQ;
        newFlags[armExecPkg::FlagN] = aluResult[Dw-1];
        newFlags[armExecPkg::FlagZ] = aluResult == '0;
        newFlags[armExecPkg::FlagC] = isArith ? sum[Dw] : shCarry;
        if (isArith) begin
            newFlags[armExecPkg::FlagV] = (addA[Dw-1] == addB[Dw-1]) &&
                                          (sum[Dw-1] != addA[Dw-1]);
        end
    end

    assign noWrite = (opCode == armExecPkg::OpTst) || (opCode == armExecPkg::OpCmp) ||
                     (opCode == armExecPkg::OpCmn);

    // Result slot must be free and no pending multiply to the same register
    assign accept = opReq && !opMul && !ackQ && !reqQ && !res.ack &&
                    !(mulBusy && (mulRd == opRd));

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            ackQ   <= 1'b0;
            reqQ   <= 1'b0;
            flagsQ <= '0;
        end else begin
            if (accept) begin
                ackQ <= 1'b1;
            end else if (!opReq) begin
                ackQ <= 1'b0;
            end
            if (accept && condPass && !noWrite) begin
                reqQ <= 1'b1;
            end else if (res.ack) begin
                reqQ <= 1'b0;
            end
            if (accept && condPass && (opSetFlags || noWrite)) begin
                flagsQ <= newFlags;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            addrQ <= opRd;
            dataQ <= aluResult;
        end
    end

    assign opAck    = ackQ;
    assign flags    = flagsQ;
    assign res.req  = reqQ;
    assign res.addr = addrQ;
    assign res.data = dataQ;

    // Register-shifted operands are not supported
    assert property (@(posedge CLK) disable iff (!rstN)
        accept && !opImm |-> !src2.regView.regShift);

    assert property (@(posedge CLK) disable iff (!rstN)
        res.req |=> !$rose(opAck));

endmodule

//--- resultIf.sv
`timescale 1ns/10ps

// One register write over a four-phase req/ack
interface resultIf;

    logic                                 req;
    logic                                 ack;
    logic [armExecPkg::RegAddrWidth-1:0]  addr;
    logic [armExecPkg::DataWidth-1:0]     data;

    modport source (
        output req,
        output addr,
        output data,
        input  ack
    );

    modport sink (
        input  req,
        input  addr,
        input  data,
        output ack
    );

endinterface

//--- armExecPkg.sv
package armExecPkg;

    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 4;

    ////////////////////////////////////////
    // Data-processing opcodes
    ////////////////////////////////////////
    localparam logic [3:0] OpAnd = 4'b0000;
    localparam logic [3:0] OpEor = 4'b0001;
    localparam logic [3:0] OpSub = 4'b0010;
    localparam logic [3:0] OpRsb = 4'b0011;
    localparam logic [3:0] OpAdd = 4'b0100;
    localparam logic [3:0] OpAdc = 4'b0101;
    localparam logic [3:0] OpTst = 4'b1000;
    localparam logic [3:0] OpCmp = 4'b1010;
    localparam logic [3:0] OpCmn = 4'b1011;
    localparam logic [3:0] OpOrr = 4'b1100;
    localparam logic [3:0] OpMov = 4'b1101;
    localparam logic [3:0] OpBic = 4'b1110;
    localparam logic [3:0] OpMvn = 4'b1111;

    // Condition field
    localparam logic [3:0] CondEq = 4'b0000;
    localparam logic [3:0] CondNe = 4'b0001;
    localparam logic [3:0] CondCs = 4'b0010;
    localparam logic [3:0] CondCc = 4'b0011;
    localparam logic [3:0] CondMi = 4'b0100;
    localparam logic [3:0] CondPl = 4'b0101;
    localparam logic [3:0] CondGe = 4'b1010;
    localparam logic [3:0] CondLt = 4'b1011;
    localparam logic [3:0] CondAl = 4'b1110;

    // Shift types
    localparam logic [1:0] ShLsl = 2'b00;
    localparam logic [1:0] ShLsr = 2'b01;
    localparam logic [1:0] ShAsr = 2'b10;
    localparam logic [1:0] ShRor = 2'b11;

    // NZCV positions in the flag word
    localparam int FlagN = 3;
    localparam int FlagZ = 2;
    localparam int FlagC = 1;
    localparam int FlagV = 0;

    ////////////////////////////////////////
    // Operand-2 field
    ////////////////////////////////////////
    typedef struct packed {
        logic [3:0] rot;
        logic [7:0] imm8;
    } src2Imm_t;

    typedef struct packed {
        logic [4:0] shAmt;
        logic [1:0] shType;
        logic       regShift;
        logic [3:0] rm;
    } src2Reg_t;

    typedef union packed {
        src2Imm_t immView;
        src2Reg_t regView;
    } src2Field_t;

endpackage
